// ==== logic/core_sizes_pkg.sv ====
// Widths of the execution slice: register numbers, ROB tags and data words
// Shared by every RTL block and the testbench through scoped names
`default_nettype none

package core_sizes_pkg;

    // Physical register file depth
    localparam int PREG_COUNT = 64;

    typedef logic [$clog2(PREG_COUNT)-1:0] preg_idx_t;
    typedef logic [4:0]                    rob_id_t;
    typedef logic [31:0]                   word_t;
    typedef logic [31:0]                   imm_t;

endpackage

`default_nettype wire

// ==== logic/exec_ops_pkg.sv ====
// Operation encoding, functional unit selection and multiplier FSM states
`default_nettype none

package exec_ops_pkg;

    typedef enum logic [2:0] {
        OP_ADD = 3'd0,
        OP_SUB = 3'd1,
        OP_AND = 3'd2,
        OP_XOR = 3'd3,
        OP_SLL = 3'd4,
        OP_IMM = 3'd5,
        OP_MUL = 3'd6
    } op_t;

    // Kept here so waveform viewers show the state names
    typedef enum logic [1:0] {
        MUL_IDLE = 2'd0,
        MUL_BUSY = 2'd1,
        MUL_DONE = 2'd2
    } mul_state_t;

    // Everything that is not a multiply goes to the ALU
    function automatic logic is_mul(op_t op);
        return op == OP_MUL;
    endfunction

endpackage

`default_nettype wire

// ==== logic/phys_reg_file.sv ====
// Physical register file with pending bits and producer tags
// Its dispatch, ALU and MUL read ports are transparent to the CDB write
`timescale 1ns/1ns
`default_nettype none

module phys_reg_file (
    input  wire logic                      clk,
    input  wire logic                      rst,
    input  wire logic                      wr_en,
    input  core_sizes_pkg::preg_idx_t      wr_preg,
    input  core_sizes_pkg::rob_id_t        wr_rob,
    input  wire logic                      cdb_valid,
    input  core_sizes_pkg::preg_idx_t      cdb_preg,
    input  core_sizes_pkg::rob_id_t        cdb_rob,
    input  core_sizes_pkg::word_t          cdb_value,
    input  core_sizes_pkg::preg_idx_t      disp_rs1,
    input  core_sizes_pkg::preg_idx_t      disp_rs2,
    output core_sizes_pkg::word_t          disp_rs1_value,
    output core_sizes_pkg::word_t          disp_rs2_value,
    output logic                           disp_rs1_pending,
    output logic                           disp_rs2_pending,
    output core_sizes_pkg::rob_id_t        disp_rs1_tag,
    output core_sizes_pkg::rob_id_t        disp_rs2_tag,
    input  core_sizes_pkg::preg_idx_t      alu_rs1,
    input  core_sizes_pkg::preg_idx_t      alu_rs2,
    output core_sizes_pkg::word_t          alu_rs1_value,
    output core_sizes_pkg::word_t          alu_rs2_value,
    output logic                           alu_rs1_pending,
    output logic                           alu_rs2_pending,
    output core_sizes_pkg::rob_id_t        alu_rs1_tag,
    output core_sizes_pkg::rob_id_t        alu_rs2_tag,
    input  core_sizes_pkg::preg_idx_t      mul_rs1,
    input  core_sizes_pkg::preg_idx_t      mul_rs2,
    output core_sizes_pkg::word_t          mul_rs1_value,
    output core_sizes_pkg::word_t          mul_rs2_value,
    output logic                           mul_rs1_pending,
    output logic                           mul_rs2_pending,
    output core_sizes_pkg::rob_id_t        mul_rs1_tag,
    output core_sizes_pkg::rob_id_t        mul_rs2_tag
);

    core_sizes_pkg::word_t   value_q   [core_sizes_pkg::PREG_COUNT];
    core_sizes_pkg::rob_id_t tag_q     [core_sizes_pkg::PREG_COUNT];
    logic                    pending_q [core_sizes_pkg::PREG_COUNT];

    // Bus writing this register right now
    function automatic logic cdb_hit(core_sizes_pkg::preg_idx_t p);
        return cdb_valid && (cdb_preg == p);
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < core_sizes_pkg::PREG_COUNT; i++) begin
                value_q[i]   <= '0;
                pending_q[i] <= 1'b0;
            end
        end else begin
            if (cdb_valid) begin
                value_q[cdb_preg]   <= cdb_value;
                pending_q[cdb_preg] <= 1'b0;
            end
            // A fresh allocation wins over a stale broadcast
            if (wr_en) begin
                pending_q[wr_preg] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_q[wr_preg] <= wr_rob;
        end
    end

    always_comb begin
        disp_rs1_value   = cdb_hit(disp_rs1) ? cdb_value : value_q[disp_rs1];
        disp_rs2_value   = cdb_hit(disp_rs2) ? cdb_value : value_q[disp_rs2];
        disp_rs1_pending = !cdb_hit(disp_rs1) && pending_q[disp_rs1];
        disp_rs2_pending = !cdb_hit(disp_rs2) && pending_q[disp_rs2];
        disp_rs1_tag     = cdb_hit(disp_rs1) ? cdb_rob : tag_q[disp_rs1];
        disp_rs2_tag     = cdb_hit(disp_rs2) ? cdb_rob : tag_q[disp_rs2];

        alu_rs1_value    = cdb_hit(alu_rs1) ? cdb_value : value_q[alu_rs1];
        alu_rs2_value    = cdb_hit(alu_rs2) ? cdb_value : value_q[alu_rs2];
        alu_rs1_pending  = !cdb_hit(alu_rs1) && pending_q[alu_rs1];
        alu_rs2_pending  = !cdb_hit(alu_rs2) && pending_q[alu_rs2];
        alu_rs1_tag      = cdb_hit(alu_rs1) ? cdb_rob : tag_q[alu_rs1];
        alu_rs2_tag      = cdb_hit(alu_rs2) ? cdb_rob : tag_q[alu_rs2];

        mul_rs1_value    = cdb_hit(mul_rs1) ? cdb_value : value_q[mul_rs1];
        mul_rs2_value    = cdb_hit(mul_rs2) ? cdb_value : value_q[mul_rs2];
        mul_rs1_pending  = !cdb_hit(mul_rs1) && pending_q[mul_rs1];
        mul_rs2_pending  = !cdb_hit(mul_rs2) && pending_q[mul_rs2];
        mul_rs1_tag      = cdb_hit(mul_rs1) ? cdb_rob : tag_q[mul_rs1];
        mul_rs2_tag      = cdb_hit(mul_rs2) ? cdb_rob : tag_q[mul_rs2];
    end

endmodule

`default_nettype wire

// ==== logic/issue_queue.sv ====
// Wait queue between dispatch and the two functional units
// Wakes entries from the CDB and issues the oldest ready entry per unit
`timescale 1ns/1ns
`default_nettype none

module issue_queue #(
    parameter int IQ_DEPTH = 8
) (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  dispatch_valid,
    output logic                       dispatch_ready,
    input  exec_ops_pkg::op_t          dispatch_op,
    input  core_sizes_pkg::preg_idx_t  dispatch_rs1,
    input  core_sizes_pkg::preg_idx_t  dispatch_rs2,
    input  core_sizes_pkg::preg_idx_t  dispatch_rd,
    input  core_sizes_pkg::rob_id_t    dispatch_rob,
    input  core_sizes_pkg::imm_t       dispatch_imm,
    input  wire logic                  disp_rs1_pending,
    input  wire logic                  disp_rs2_pending,
    input  wire logic                  cdb_valid,
    input  core_sizes_pkg::preg_idx_t  cdb_preg,
    output logic                       alu_issue_valid,
    input  wire logic                  alu_issue_ready,
    output exec_ops_pkg::op_t          alu_issue_op,
    output core_sizes_pkg::preg_idx_t  alu_issue_rd,
    output core_sizes_pkg::rob_id_t    alu_issue_rob,
    output core_sizes_pkg::imm_t       alu_issue_imm,
    output core_sizes_pkg::preg_idx_t  alu_issue_rs1,
    output core_sizes_pkg::preg_idx_t  alu_issue_rs2,
    output logic                       mul_issue_valid,
    input  wire logic                  mul_issue_ready,
    output core_sizes_pkg::preg_idx_t  mul_issue_rd,
    output core_sizes_pkg::rob_id_t    mul_issue_rob,
    output core_sizes_pkg::preg_idx_t  mul_issue_rs1,
    output core_sizes_pkg::preg_idx_t  mul_issue_rs2
);

    localparam int IDX_W = $clog2(IQ_DEPTH);
    localparam int AGE_W = IDX_W + 2;

    logic [IQ_DEPTH-1:0]       valid_q, valid_n, p1_q, p2_q;
    logic                      ready_q;
    exec_ops_pkg::op_t         op_q  [IQ_DEPTH];
    core_sizes_pkg::preg_idx_t rs1_q [IQ_DEPTH];
    core_sizes_pkg::preg_idx_t rs2_q [IQ_DEPTH];
    core_sizes_pkg::preg_idx_t rd_q  [IQ_DEPTH];
    core_sizes_pkg::rob_id_t   rob_q [IQ_DEPTH];
    core_sizes_pkg::imm_t      imm_q [IQ_DEPTH];
    logic [AGE_W-1:0]          age_q [IQ_DEPTH];

    logic             alu_found, mul_found, alu_fire, mul_fire, disp_fire;
    logic [IDX_W-1:0] alu_sel, mul_sel, ins_sel;

    assign dispatch_ready = ready_q;
    assign disp_fire      = dispatch_valid && dispatch_ready;
    assign alu_fire       = alu_issue_valid && alu_issue_ready;
    assign mul_fire       = mul_issue_valid && mul_issue_ready;

    // Oldest ready entry per unit, lowest free slot for insertion
    always_comb begin
        alu_found = 1'b0;
        mul_found = 1'b0;
        alu_sel   = '0;
        mul_sel   = '0;
        ins_sel   = '0;
        for (int i = IQ_DEPTH - 1; i >= 0; i--) begin
            if (!valid_q[i]) begin
                ins_sel = IDX_W'(i);
            end
        end
        for (int i = 0; i < IQ_DEPTH; i++) begin
            if (valid_q[i] && !p1_q[i] && !p2_q[i]) begin
                if (exec_ops_pkg::is_mul(op_q[i])) begin
                    if (!mul_found || age_q[i] > age_q[mul_sel]) begin
                        mul_found = 1'b1;
                        mul_sel   = IDX_W'(i);
                    end
                end else if (!alu_found || age_q[i] > age_q[alu_sel]) begin
                    alu_found = 1'b1;
                    alu_sel   = IDX_W'(i);
                end
            end
        end
    end

    always_comb begin
        valid_n = valid_q;
        if (alu_fire) valid_n[alu_sel] = 1'b0;
        if (mul_fire) valid_n[mul_sel] = 1'b0;
        if (disp_fire) valid_n[ins_sel] = 1'b1;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
            ready_q <= 1'b0;
        end else begin
            valid_q <= valid_n;
            ready_q <= |(~valid_n);
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < IQ_DEPTH; i++) begin
            if (cdb_valid && rs1_q[i] == cdb_preg) p1_q[i] <= 1'b0;
            if (cdb_valid && rs2_q[i] == cdb_preg) p2_q[i] <= 1'b0;
            // Saturating, ties fall to the lower slot
            if (disp_fire && valid_q[i] && age_q[i] != '1) begin
                age_q[i] <= age_q[i] + AGE_W'(1);
            end
        end
        if (disp_fire) begin
            op_q[ins_sel]  <= dispatch_op;
            rs1_q[ins_sel] <= dispatch_rs1;
            rs2_q[ins_sel] <= dispatch_rs2;
            rd_q[ins_sel]  <= dispatch_rd;
            rob_q[ins_sel] <= dispatch_rob;
            imm_q[ins_sel] <= dispatch_imm;
            age_q[ins_sel] <= '0;
            // OP_IMM reads no sources
            p1_q[ins_sel]  <= disp_rs1_pending && dispatch_op != exec_ops_pkg::OP_IMM;
            p2_q[ins_sel]  <= disp_rs2_pending && dispatch_op != exec_ops_pkg::OP_IMM;
        end
    end

    assign alu_issue_valid = alu_found;
    assign alu_issue_op    = op_q[alu_sel];
    assign alu_issue_rd    = rd_q[alu_sel];
    assign alu_issue_rob   = rob_q[alu_sel];
    assign alu_issue_imm   = imm_q[alu_sel];
    assign alu_issue_rs1   = rs1_q[alu_sel];
    assign alu_issue_rs2   = rs2_q[alu_sel];

    assign mul_issue_valid = mul_found;
    assign mul_issue_rd    = rd_q[mul_sel];
    assign mul_issue_rob   = rob_q[mul_sel];
    assign mul_issue_rs1   = rs1_q[mul_sel];
    assign mul_issue_rs2   = rs2_q[mul_sel];

endmodule

`default_nettype wire

// ==== logic/alu_unit.sv ====
// Single-cycle ALU, result held in a register until the CDB arbiter takes it
`timescale 1ns/1ns
`default_nettype none

module alu_unit (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  issue_valid,
    output logic                       issue_ready,
    input  exec_ops_pkg::op_t          op,
    input  core_sizes_pkg::preg_idx_t  rd,
    input  core_sizes_pkg::rob_id_t    rob,
    input  core_sizes_pkg::imm_t       imm,
    input  core_sizes_pkg::word_t      a,
    input  core_sizes_pkg::word_t      b,
    output logic                       res_valid,
    input  wire logic                  res_ready,
    output core_sizes_pkg::preg_idx_t  res_preg,
    output core_sizes_pkg::rob_id_t    res_rob,
    output core_sizes_pkg::word_t      res_value
);

    core_sizes_pkg::word_t alu_out;
    logic                  issue_fire;

    // Free, or the held result leaves this cycle
    assign issue_ready = !res_valid || res_ready;
    assign issue_fire  = issue_valid && issue_ready;

    always_comb begin
        case (op)
            exec_ops_pkg::OP_ADD: alu_out = a + b;
            exec_ops_pkg::OP_SUB: alu_out = a - b;
            exec_ops_pkg::OP_AND: alu_out = a & b;
            exec_ops_pkg::OP_XOR: alu_out = a ^ b;
            exec_ops_pkg::OP_SLL: alu_out = a << b[4:0];
            exec_ops_pkg::OP_IMM: alu_out = imm;
            default:              alu_out = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            res_valid <= 1'b0;
        end else if (issue_fire) begin
            res_valid <= 1'b1;
        end else if (res_ready) begin
            res_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_fire) begin
            res_preg  <= rd;
            res_rob   <= rob;
            res_value <= alu_out;
        end
    end

endmodule

`default_nettype wire

// ==== logic/mul_unit.sv ====
// Iterative multiplier, one MUL_CHUNK-bit slice of b per busy cycle
// Returns the low word of the product, takes no new work while busy or holding
`timescale 1ns/1ns
`default_nettype none

module mul_unit #(
    parameter int MUL_CHUNK = 8
) (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  issue_valid,
    output logic                       issue_ready,
    input  core_sizes_pkg::preg_idx_t  rd,
    input  core_sizes_pkg::rob_id_t    rob,
    input  core_sizes_pkg::word_t      a,
    input  core_sizes_pkg::word_t      b,
    output logic                       res_valid,
    input  wire logic                  res_ready,
    output core_sizes_pkg::preg_idx_t  res_preg,
    output core_sizes_pkg::rob_id_t    res_rob,
    output core_sizes_pkg::word_t      res_value
);

    localparam int STEPS = $bits(core_sizes_pkg::word_t) / MUL_CHUNK;
    localparam int CNT_W = (STEPS > 1) ? $clog2(STEPS) : 1;

    exec_ops_pkg::mul_state_t state_q;
    logic [CNT_W-1:0]         step_q;
    core_sizes_pkg::word_t    a_q, b_q, acc_q;

    assign issue_ready = (state_q == exec_ops_pkg::MUL_IDLE);
    assign res_valid   = (state_q == exec_ops_pkg::MUL_DONE);
    assign res_value   = acc_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= exec_ops_pkg::MUL_IDLE;
            step_q  <= '0;
        end else begin
            case (state_q)
                exec_ops_pkg::MUL_IDLE: begin
                    if (issue_valid) begin
                        state_q <= exec_ops_pkg::MUL_BUSY;
                        step_q  <= '0;
                    end
                end
                exec_ops_pkg::MUL_BUSY: begin
                    step_q <= step_q + CNT_W'(1);
                    if (step_q == CNT_W'(STEPS - 1)) begin
                        state_q <= exec_ops_pkg::MUL_DONE;
                    end
                end
                exec_ops_pkg::MUL_DONE: begin
                    if (res_ready) state_q <= exec_ops_pkg::MUL_IDLE;
                end
                default: state_q <= exec_ops_pkg::MUL_IDLE;
            endcase
        end
    end

    // a moves up as b moves down, so each partial product lands in place
    always_ff @(posedge clk) begin
        if (issue_valid && issue_ready) begin
            a_q      <= a;
            b_q      <= b;
            acc_q    <= '0;
            res_preg <= rd;
            res_rob  <= rob;
        end else if (state_q == exec_ops_pkg::MUL_BUSY) begin
            acc_q <= acc_q + a_q * core_sizes_pkg::word_t'(b_q[MUL_CHUNK-1:0]);
            a_q   <= a_q << MUL_CHUNK;
            b_q   <= b_q >> MUL_CHUNK;
        end
    end

endmodule

`default_nettype wire

// ==== logic/cdb_arbiter.sv ====
// Picks one unit result per cycle, multiplier first, and registers it onto the CDB
`timescale 1ns/1ns
`default_nettype none

module cdb_arbiter (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  alu_res_valid,
    output logic                       alu_res_ready,
    input  core_sizes_pkg::preg_idx_t  alu_res_preg,
    input  core_sizes_pkg::rob_id_t    alu_res_rob,
    input  core_sizes_pkg::word_t      alu_res_value,
    input  wire logic                  mul_res_valid,
    output logic                       mul_res_ready,
    input  core_sizes_pkg::preg_idx_t  mul_res_preg,
    input  core_sizes_pkg::rob_id_t    mul_res_rob,
    input  core_sizes_pkg::word_t      mul_res_value,
    output logic                       cdb_valid,
    output core_sizes_pkg::preg_idx_t  cdb_preg,
    output core_sizes_pkg::rob_id_t    cdb_rob,
    output core_sizes_pkg::word_t      cdb_value
);

    // ALU waits whenever the multiplier has a result
    assign mul_res_ready = mul_res_valid;
    assign alu_res_ready = alu_res_valid && !mul_res_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            cdb_valid <= 1'b0;
        end else begin
            cdb_valid <= mul_res_valid || alu_res_valid;
        end
    end

    always_ff @(posedge clk) begin
        cdb_preg  <= mul_res_valid ? mul_res_preg  : alu_res_preg;
        cdb_rob   <= mul_res_valid ? mul_res_rob   : alu_res_rob;
        cdb_value <= mul_res_valid ? mul_res_value : alu_res_value;
    end

endmodule

`default_nettype wire

// ==== logic/exec_core.sv ====
// Execution slice top: register file, issue queue, ALU, multiplier and CDB arbiter
// Takes renamed instructions on dispatch and streams completions out on the CDB
`timescale 1ns/1ns
`default_nettype none

module exec_core #(
    parameter int IQ_DEPTH  = 8,
    parameter int MUL_CHUNK = 8
) (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  dispatch_valid,
    output logic                       dispatch_ready,
    input  exec_ops_pkg::op_t          dispatch_op,
    input  core_sizes_pkg::preg_idx_t  dispatch_rs1,
    input  core_sizes_pkg::preg_idx_t  dispatch_rs2,
    input  core_sizes_pkg::preg_idx_t  dispatch_rd,
    input  core_sizes_pkg::rob_id_t    dispatch_rob,
    input  core_sizes_pkg::imm_t       dispatch_imm,
    output logic                       cdb_valid,
    output core_sizes_pkg::preg_idx_t  cdb_preg,
    output core_sizes_pkg::rob_id_t    cdb_rob,
    output core_sizes_pkg::word_t      cdb_value
);

    logic                      dispatch_fire, disp_rs1_pending, disp_rs2_pending;
    logic                      alu_issue_valid, alu_issue_ready;
    exec_ops_pkg::op_t         alu_issue_op;
    core_sizes_pkg::preg_idx_t alu_issue_rd, alu_issue_rs1, alu_issue_rs2;
    core_sizes_pkg::rob_id_t   alu_issue_rob;
    core_sizes_pkg::imm_t      alu_issue_imm;
    core_sizes_pkg::word_t     alu_a, alu_b;
    logic                      mul_issue_valid, mul_issue_ready;
    core_sizes_pkg::preg_idx_t mul_issue_rd, mul_issue_rs1, mul_issue_rs2;
    core_sizes_pkg::rob_id_t   mul_issue_rob;
    core_sizes_pkg::word_t     mul_a, mul_b;
    logic                      alu_res_valid, alu_res_ready, mul_res_valid, mul_res_ready;
    core_sizes_pkg::preg_idx_t alu_res_preg, mul_res_preg;
    core_sizes_pkg::rob_id_t   alu_res_rob, mul_res_rob;
    core_sizes_pkg::word_t     alu_res_value, mul_res_value;

    assign dispatch_fire = dispatch_valid && dispatch_ready;

    phys_reg_file i_prf (
        .clk, .rst,
        .wr_en(dispatch_fire), .wr_preg(dispatch_rd), .wr_rob(dispatch_rob),
        .cdb_valid, .cdb_preg, .cdb_rob, .cdb_value,
        .disp_rs1(dispatch_rs1), .disp_rs2(dispatch_rs2),
        .disp_rs1_value(), .disp_rs2_value(),
        .disp_rs1_pending, .disp_rs2_pending,
        .disp_rs1_tag(), .disp_rs2_tag(),
        .alu_rs1(alu_issue_rs1), .alu_rs2(alu_issue_rs2),
        .alu_rs1_value(alu_a), .alu_rs2_value(alu_b),
        .alu_rs1_pending(), .alu_rs2_pending(), .alu_rs1_tag(), .alu_rs2_tag(),
        .mul_rs1(mul_issue_rs1), .mul_rs2(mul_issue_rs2),
        .mul_rs1_value(mul_a), .mul_rs2_value(mul_b),
        .mul_rs1_pending(), .mul_rs2_pending(), .mul_rs1_tag(), .mul_rs2_tag()
    );

    issue_queue #(.IQ_DEPTH(IQ_DEPTH)) i_iq (
        .clk, .rst,
        .dispatch_valid, .dispatch_ready, .dispatch_op, .dispatch_rs1, .dispatch_rs2,
        .dispatch_rd, .dispatch_rob, .dispatch_imm, .disp_rs1_pending, .disp_rs2_pending,
        .cdb_valid, .cdb_preg,
        .alu_issue_valid, .alu_issue_ready, .alu_issue_op, .alu_issue_rd, .alu_issue_rob,
        .alu_issue_imm, .alu_issue_rs1, .alu_issue_rs2,
        .mul_issue_valid, .mul_issue_ready, .mul_issue_rd, .mul_issue_rob,
        .mul_issue_rs1, .mul_issue_rs2
    );

    alu_unit i_alu (
        .clk, .rst,
        .issue_valid(alu_issue_valid), .issue_ready(alu_issue_ready), .op(alu_issue_op),
        .rd(alu_issue_rd), .rob(alu_issue_rob), .imm(alu_issue_imm), .a(alu_a), .b(alu_b),
        .res_valid(alu_res_valid), .res_ready(alu_res_ready), .res_preg(alu_res_preg),
        .res_rob(alu_res_rob), .res_value(alu_res_value)
    );

    mul_unit #(.MUL_CHUNK(MUL_CHUNK)) i_mul (
        .clk, .rst,
        .issue_valid(mul_issue_valid), .issue_ready(mul_issue_ready),
        .rd(mul_issue_rd), .rob(mul_issue_rob), .a(mul_a), .b(mul_b),
        .res_valid(mul_res_valid), .res_ready(mul_res_ready), .res_preg(mul_res_preg),
        .res_rob(mul_res_rob), .res_value(mul_res_value)
    );

    cdb_arbiter i_arb (
        .clk, .rst,
        .alu_res_valid, .alu_res_ready, .alu_res_preg, .alu_res_rob, .alu_res_value,
        .mul_res_valid, .mul_res_ready, .mul_res_preg, .mul_res_rob, .mul_res_value,
        .cdb_valid, .cdb_preg, .cdb_rob, .cdb_value
    );

endmodule

`default_nettype wire

// ==== verif/exec_model.svh ====
// Reference model of the execution slice, included inside the testbench module
// Tracks the expected value, producer tag and outstanding state of each register
`ifndef EXEC_MODEL_SVH
`define EXEC_MODEL_SVH

core_sizes_pkg::word_t   model_value [core_sizes_pkg::PREG_COUNT];
core_sizes_pkg::rob_id_t model_tag   [core_sizes_pkg::PREG_COUNT];
bit                      outstanding [core_sizes_pkg::PREG_COUNT];
int                      outstanding_count;

// Registers read as zero after reset
task automatic reset_model();
    for (int i = 0; i < core_sizes_pkg::PREG_COUNT; i++) begin
        model_value[i] = '0;
        model_tag[i]   = '0;
        outstanding[i] = 1'b0;
    end
    outstanding_count = 0;
endtask

function automatic core_sizes_pkg::word_t compute_result(exec_ops_pkg::op_t op,
        core_sizes_pkg::word_t a, core_sizes_pkg::word_t b, core_sizes_pkg::imm_t imm);
    case (op)
        exec_ops_pkg::OP_ADD: return a + b;
        exec_ops_pkg::OP_SUB: return a - b;
        exec_ops_pkg::OP_AND: return a & b;
        exec_ops_pkg::OP_XOR: return a ^ b;
        exec_ops_pkg::OP_SLL: return a << b[4:0];
        exec_ops_pkg::OP_IMM: return imm;
        // Low word of the full product
        exec_ops_pkg::OP_MUL: return a * b;
        default:              return '0;
    endcase
endfunction

// Destinations are fresh, so the value is known at dispatch time
task automatic record_dispatch(exec_ops_pkg::op_t op, core_sizes_pkg::preg_idx_t rs1,
        core_sizes_pkg::preg_idx_t rs2, core_sizes_pkg::preg_idx_t rd,
        core_sizes_pkg::rob_id_t rob, core_sizes_pkg::imm_t imm);
    model_value[rd] = compute_result(op, model_value[rs1], model_value[rs2], imm);
    model_tag[rd]   = rob;
    outstanding[rd] = 1'b1;
    outstanding_count++;
endtask

task automatic retire_result(core_sizes_pkg::preg_idx_t preg, core_sizes_pkg::rob_id_t rob,
        core_sizes_pkg::word_t value);
    check_value("cdb_preg outstanding", 32'(outstanding[preg]), 32'd1);
    check_value("cdb_rob", 32'(rob), 32'(model_tag[preg]));
    check_value("cdb_value", value, model_value[preg]);
    outstanding[preg] = 1'b0;
    outstanding_count--;
endtask

`endif

// ==== verif/exec_core_tb.sv ====
// Drives random dispatch batches into the execution slice and checks the CDB against a model
// Ends with $finish once every batch completes and with $fatal at the first error or on timeout
`timescale 1ns/1ns
`default_nettype none

module exec_core_tb;

    localparam int NUM_BATCHES      = 6;
    localparam int BATCH_MAX        = 48;
    localparam int CYCLES_PER_INSTR = 12;

    logic                      clk, rst, dispatch_valid, dispatch_ready, cdb_valid;
    exec_ops_pkg::op_t         dispatch_op;
    core_sizes_pkg::preg_idx_t dispatch_rs1, dispatch_rs2, dispatch_rd, cdb_preg;
    core_sizes_pkg::rob_id_t   dispatch_rob, cdb_rob;
    core_sizes_pkg::imm_t      dispatch_imm;
    core_sizes_pkg::word_t     cdb_value;

    logic [31:0]               lfsr_state;
    core_sizes_pkg::rob_id_t   next_rob;
    bit                        saw_stall;
    string                     step;

    exec_core #(.IQ_DEPTH(8), .MUL_CHUNK(8)) i_dut (
        .clk, .rst,
        .dispatch_valid, .dispatch_ready, .dispatch_op, .dispatch_rs1, .dispatch_rs2,
        .dispatch_rd, .dispatch_rob, .dispatch_imm,
        .cdb_valid, .cdb_preg, .cdb_rob, .cdb_value
    );

    task automatic check_value(input string name, input logic [31:0] got,
            input logic [31:0] expected);
        if (got !== expected) begin
            $display("FAILED at %0t ns: %s = %h, expected %h", $time, name, got, expected);
            $display("** FAIL **");
            $fatal(1, "value mismatch");
        end
    endtask

    `include "exec_model.svh"

    // Galois LFSR stepped once per returned bit
    function automatic logic [31:0] lfsr_bits(input int count);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < count; i++) begin
            r = {r[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'h8020_0003 : lfsr_state >> 1;
        end
        return r;
    endfunction

    // Entered at a falling edge and returns at the falling edge after the transfer
    task automatic send_instr(input exec_ops_pkg::op_t op, input core_sizes_pkg::preg_idx_t rs1,
            input core_sizes_pkg::preg_idx_t rs2, input core_sizes_pkg::preg_idx_t rd,
            input core_sizes_pkg::imm_t imm);
        dispatch_valid = 1'b1;
        dispatch_op    = op;
        dispatch_rs1   = rs1;
        dispatch_rs2   = rs2;
        dispatch_rd    = rd;
        dispatch_rob   = next_rob;
        dispatch_imm   = imm;
        // Ready only moves on a rising edge so this value is what the edge sees
        while (!dispatch_ready) begin
            saw_stall = 1'b1;
            @(negedge clk);
        end
        record_dispatch(op, rs1, rs2, rd, next_rob, imm);
        next_rob = next_rob + 5'd1;
        @(negedge clk);
        dispatch_valid = 1'b0;
    endtask

    // Mode 0 is random with gaps, 1 a dependent chain and 2 a multiply burst
    task automatic run_batch(input int mode, input int count);
        exec_ops_pkg::op_t         op;
        core_sizes_pkg::preg_idx_t rs1, rs2;
        logic [2:0]                code;
        for (int i = 0; i < count; i++) begin
            op  = exec_ops_pkg::OP_IMM;
            rs1 = '0;
            rs2 = '0;
            if (i >= 4) begin
                code = 3'(lfsr_bits(3));
                if (mode == 2 || code == 3'd7) begin
                    op = exec_ops_pkg::OP_MUL;
                end else begin
                    op = exec_ops_pkg::op_t'(code);
                end
                rs1 = core_sizes_pkg::preg_idx_t'(lfsr_bits(6) % 32'(i));
                rs2 = core_sizes_pkg::preg_idx_t'(lfsr_bits(6) % 32'(i));
                if (mode == 1 || lfsr_bits(2) == 32'd0) begin
                    rs1 = core_sizes_pkg::preg_idx_t'(i - 1);
                end
            end
            send_instr(op, rs1, rs2, core_sizes_pkg::preg_idx_t'(i), lfsr_bits(32));
            if (mode == 0 && lfsr_bits(2) == 32'd0) begin
                repeat (int'(lfsr_bits(2))) @(negedge clk);
            end
        end
    endtask

    task automatic drain();
        while (outstanding_count != 0) begin
            @(negedge clk);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // CDB outputs are registered and stable at the falling edge
    always @(negedge clk) begin
        if (!rst && cdb_valid) begin
            retire_result(cdb_preg, cdb_rob, cdb_value);
        end
    end

    initial begin
        repeat (NUM_BATCHES * BATCH_MAX * CYCLES_PER_INSTR + 200) @(posedge clk);
        $display("Timeout: the run made no progress during %s", step);
        $display("** FAIL **");
        $fatal(1, "watchdog expired");
    end

    initial begin
        int count;
        rst            = 1'b1;
        dispatch_valid = 1'b0;
        dispatch_op    = exec_ops_pkg::OP_ADD;
        dispatch_rs1   = '0;
        dispatch_rs2   = '0;
        dispatch_rd    = '0;
        dispatch_rob   = '0;
        dispatch_imm   = '0;
        lfsr_state     = 32'h1a27fd55;
        next_rob       = '0;
        saw_stall      = 1'b0;
        step           = "reset";
        reset_model();

        repeat (2) @(posedge clk);
        @(negedge clk);
        check_value("dispatch_ready", 32'(dispatch_ready), 32'd0);
        @(negedge clk);
        rst = 1'b0;

        step = "idle after reset";
        repeat (4) begin
            @(negedge clk);
            check_value("cdb_valid", 32'(cdb_valid), 32'd0);
        end

        // Registers 57 to 63 are never allocated by the batches
        step = "reads of never written registers";
        send_instr(exec_ops_pkg::OP_XOR, 6'd62, 6'd63, 6'd60, 32'h0000_1234);
        send_instr(exec_ops_pkg::OP_ADD, 6'd61, 6'd62, 6'd59, 32'h0000_5678);
        drain();

        // The ADD is accepted in the cycle the OP_IMM result is on the CDB
        step = "dispatch during a broadcast of its source";
        send_instr(exec_ops_pkg::OP_IMM, 6'd0, 6'd0, 6'd58, 32'h0bad_cafe);
        repeat (2) @(negedge clk);
        check_value("cdb_valid", 32'(cdb_valid), 32'd1);
        check_value("cdb_preg", 32'(cdb_preg), 32'd58);
        send_instr(exec_ops_pkg::OP_ADD, 6'd58, 6'd58, 6'd57, 32'h0000_0000);
        drain();

        for (int b = 0; b < NUM_BATCHES; b++) begin
            step = $sformatf("dispatch of batch %0d", b);
            count = (b % 3 == 2) ? BATCH_MAX - 8 : 17 + int'(lfsr_bits(5));
            saw_stall = 1'b0;
            run_batch(b % 3, count);
            step = $sformatf("drain of batch %0d", b);
            drain();
            if (b % 3 == 2) begin
                check_value("dispatch_ready low in multiply burst", 32'(saw_stall), 32'd1);
            end
        end

        step = "final quiet period";
        repeat (10) @(negedge clk);
        // Queue is empty again, so a slot is free
        check_value("dispatch_ready", 32'(dispatch_ready), 32'd1);
        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+verif
logic/core_sizes_pkg.sv
logic/exec_ops_pkg.sv
logic/phys_reg_file.sv
logic/issue_queue.sv
logic/alu_unit.sv
logic/mul_unit.sv
logic/cdb_arbiter.sv
logic/exec_core.sv
verif/exec_core_tb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the execution slice testbench with Verilator and runs it
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ns -f vlog.f \
    --top-module exec_core_tb -Mdir obj_dir -o exec_core_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/exec_core_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit "$status"
fi

exit 0
